/* list.f */
+incdir+verilog
+incdir+test
verilog/sound_pkg.sv
verilog/dac_boxcar.sv
verilog/speech_biquad.sv
verilog/speech_lpf.sv
verilog/audio_mixer.sv
verilog/williams_sound.sv
test/tb_williams_sound.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the sound path testbench with Verilator and run it.
# Exit status is zero only when the run reports a pass.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
	-f list.f \
	--top-module tb_williams_sound \
	--Mdir obj_dir \
	-o tb_williams_sound
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/tb_williams_sound)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx "Result: PASSED"; then
	exit 0
fi
exit 1

/* test/sound_model.svh */
////////////////////
// Reference model of the sound path, in plain integer math.
// Included inside the testbench module after the package
// import. Filter history is kept by the caller.
////////////////////

`ifndef SOUND_MODEL_SVH
`define SOUND_MODEL_SVH

// Mean of one window from the sum of its samples
function automatic dac_level_t window_average(input int unsigned sum);
	return dac_level_t'(sum >> `SND_WINDOW_BITS);
endfunction

// Offset binary to signed value and back
function automatic int speech_to_pcm(input speech_word_t word);
	return int'(word) - 32768;
endfunction

function automatic speech_word_t pcm_to_word(input int pcm);
	return speech_word_t'(pcm + 32768);
endfunction

function automatic int clamp16(input longint value);
	if (value > 32767)
		return 32767;
	if (value < -32768)
		return -32768;
	return int'(value);
endfunction

// One step of b1*x + b2*x1 + b3*x2 - a2*y1 - a3*y2, scaled down
function automatic int biquad_ref(
	input longint b1, input longint b2, input longint b3,
	input longint a2, input longint a3,
	input longint x, input longint x1, input longint x2,
	input longint y1, input longint y2
);
	longint acc;
	acc = b1 * x + b2 * x1 + b3 * x2 - a2 * y1 - a3 * y2;
	return clamp16(acc >>> `SND_COEFF_SCALE);
endfunction

function automatic int gain_ref(input int pcm);
	return clamp16(longint'(pcm) * (1 << `SND_GAIN_SHIFT));
endfunction

// Level in the upper byte plus speech, scaled to the output word
function automatic audio_word_t mix_ref(input dac_level_t level, input speech_word_t speech);
	int unsigned total;
	total = int'(level) * 256 + int'(speech);
	return audio_word_t'(total >> `SND_MIX_SHIFT);
endfunction

`endif

/* test/tb_williams_sound.sv */
////////////////////
// Testbench of the sound output path.
// Drives DAC and speech per window, predicts every output with
// the reference model and checks values and strobe shape.
////////////////////

`default_nettype none

`include "sound_macros.svh"

module tb_williams_sound import sound_pkg::*;;

`include "sound_model.svh"

	localparam int TIMEOUT_CYCLES = 2000;
	localparam int DAC_RANDOM = 0;
	localparam int DAC_FULL = 1;
	localparam int SPEECH_RANDOM = 0;
	localparam int SPEECH_MID = 1;
	localparam int SPEECH_SWING = 2;
	// Windows per half period of the clipping pattern
	localparam int SWING_RUN = 6;

	logic         clk_sys;
	logic         reset;
	dac_level_t   dac_level;
	speech_word_t speech_word;
	logic         sinistar_board;
	audio_word_t  audio_out;
	logic         audio_valid;

	audio_word_t  expect_q[$];
	int           win_cnt;
	int unsigned  win_sum;
	int           st1_x1;
	int           st1_x2;
	int           st1_y1;
	int           st1_y2;
	int           st2_x1;
	int           st2_x2;
	int           st2_y1;
	int           st2_y2;
	int           pcm_in;
	int           stage1_out;
	int           stage2_out;
	int           boosted;
	int           clip_count;
	logic         valid_prev;
	int           reset_edges;
	int           since_reset;
	int           strobe_gap;
	bit           seen_strobe;
	int           error_count;
	int           tests_passed;
	int           tests_failed;
	bit           timed_out;

	williams_sound i_williams_sound (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.dac_level     (dac_level),
		.speech_word   (speech_word),
		.sinistar_board(sinistar_board),
		.audio_out     (audio_out),
		.audio_valid   (audio_valid)
	);

	always #5 clk_sys = ~clk_sys;

	////////////////////
	// Checks
	////////////////////

	task automatic check_audio(input audio_word_t expected, input audio_word_t actual);
		if (actual !== expected) begin
			$display("CHECK FAILED audio_out expected 0x%04h actual 0x%04h at %0t",
				expected, actual, $time);
			error_count++;
		end
	endtask

	task automatic check_valid_width(input logic valid, input logic valid_last);
		if (valid === 1'b1 && valid_last === 1'b1) begin
			$display("CHECK FAILED audio_valid expected 0x0 actual 0x1 at %0t", $time);
			error_count++;
		end
	endtask

	task automatic check_strobe_gap(input int expected, input int actual);
		if (actual != expected) begin
			$display("CHECK FAILED strobe_gap expected 0x%0h actual 0x%0h", expected, actual);
			error_count++;
		end
	endtask

	////////////////////
	// Model side
	////////////////////

	// Runs the model for one closed window and queues the result
	task automatic predict_window();
		dac_level_t   avg;
		speech_word_t speech_sel;
		avg = window_average(win_sum);
		pcm_in = speech_to_pcm(speech_word);
		stage1_out = biquad_ref(`SND_LPF1_B1, `SND_LPF1_B2, `SND_LPF1_B3, `SND_LPF1_A2,
			`SND_LPF1_A3, pcm_in, st1_x1, st1_x2, st1_y1, st1_y2);
		st1_x2 = st1_x1;
		st1_x1 = pcm_in;
		st1_y2 = st1_y1;
		st1_y1 = stage1_out;
		stage2_out = biquad_ref(`SND_LPF2_B1, `SND_LPF2_B2, `SND_LPF2_B3, `SND_LPF2_A2,
			`SND_LPF2_A3, stage1_out, st2_x1, st2_x2, st2_y1, st2_y2);
		st2_x2 = st2_x1;
		st2_x1 = stage1_out;
		st2_y2 = st2_y1;
		st2_y1 = stage2_out;
		boosted = gain_ref(stage2_out);
		if (boosted != stage2_out * (1 << `SND_GAIN_SHIFT))
			clip_count++;
		speech_sel = sinistar_board ? pcm_to_word(boosted) : speech_word;
		expect_q.push_back(mix_ref(avg, speech_sel));
	endtask

	always @(posedge clk_sys) begin
		if (reset) begin
			win_cnt = 0;
			win_sum = 0;
			{st1_x1, st1_x2, st1_y1, st1_y2} = '0;
			{st2_x1, st2_x2, st2_y1, st2_y2} = '0;
		end else begin
			win_sum = win_sum + int'(dac_level);
			if (win_cnt == `SND_WINDOW_LEN - 1) begin
				predict_window();
				win_cnt = 0;
				win_sum = 0;
			end else begin
				win_cnt++;
			end
		end
	end

	// Compares every output strobe with the queue
	always @(posedge clk_sys) begin
		check_valid_width(audio_valid, valid_prev);
		if (reset) begin
			if (reset_edges > 0 && audio_valid !== 1'b0) begin
				$display("audio_valid was not low during reset");
				error_count++;
			end
			reset_edges++;
			since_reset = 0;
			strobe_gap = 0;
			seen_strobe = 0;
		end else begin
			strobe_gap++;
			if (audio_valid === 1'b1) begin
				if (since_reset < `SND_WINDOW_LEN) begin
					$display("audio_valid rose before the first window closed");
					error_count++;
				end
				if (seen_strobe)
					check_strobe_gap(`SND_WINDOW_LEN, strobe_gap);
				if (expect_q.size() == 0) begin
					$display("audio_valid arrived with no expected sample pending");
					error_count++;
				end else begin
					check_audio(expect_q.pop_front(), audio_out);
				end
				strobe_gap = 0;
				seen_strobe = 1;
			end
			since_reset++;
		end
		valid_prev = audio_valid;
	end

	////////////////////
	// Stimulus
	////////////////////

	function automatic dac_level_t next_dac(input int mode);
		if (mode == DAC_FULL)
			return 8'hFF;
		return dac_level_t'($urandom);
	endfunction

	function automatic speech_word_t next_speech(input int mode, input int window);
		if (mode == SPEECH_MID)
			return 16'h8000;
		if (mode == SPEECH_SWING)
			return ((window / SWING_RUN) % 2) ? 16'hFFFF : 16'h0000;
		return speech_word_t'($urandom);
	endfunction

	// One output per window with new speech after each strobe
	task automatic run_windows(input int windows, input logic sinistar,
		input int dac_mode, input int speech_mode);
		int w;
		int waited;
		for (w = 0; w < windows && !timed_out; w++) begin
			sinistar_board <= sinistar;
			speech_word <= next_speech(speech_mode, w);
			waited = 0;
			do begin
				@(posedge clk_sys);
				dac_level <= next_dac(dac_mode);
				waited++;
			end while (audio_valid !== 1'b1 && waited < TIMEOUT_CYCLES);
			if (audio_valid !== 1'b1) begin
				$display("Timeout: no audio_valid within %0d cycles", TIMEOUT_CYCLES);
				error_count++;
				timed_out = 1;
			end
		end
	endtask

	task automatic run_test(input string name, input int windows, input logic sinistar,
		input int dac_mode, input int speech_mode);
		int start_errors;
		start_errors = error_count;
		clip_count = 0;
		if (timed_out) begin
			$display("Test %-22s not run", name);
			tests_failed++;
		end else begin
			run_windows(windows, sinistar, dac_mode, speech_mode);
			if (!timed_out && speech_mode == SPEECH_SWING && clip_count == 0) begin
				$display("Speech swing never drove the gain stage into clipping");
				error_count++;
			end
			repeat (2) @(posedge clk_sys);
			if (expect_q.size() != 0) begin
				$display("%0d expected samples never came out", expect_q.size());
				error_count++;
			end
			if (error_count == start_errors) begin
				$display("Test %-22s passed, %0d windows", name, windows);
				tests_passed++;
			end else begin
				$display("Test %-22s failed, %0d errors", name, error_count - start_errors);
				tests_failed++;
			end
		end
	endtask

	initial begin
		void'($urandom(90097));
		clk_sys = 1'b0;
		reset = 1'b1;
		dac_level = '0;
		speech_word = 16'h8000;
		sinistar_board = 1'b0;
		valid_prev = 1'b0;
		reset_edges = 0;
		error_count = 0;
		tests_passed = 0;
		tests_failed = 0;
		timed_out = 0;
		repeat (4) @(posedge clk_sys);
		reset <= 1'b0;

		run_test("reset", 1, 1'b0, DAC_RANDOM, SPEECH_RANDOM);
		run_test("dac average raw speech", 20, 1'b0, DAC_RANDOM, SPEECH_RANDOM);
		run_test("constant inputs", 8, 1'b0, DAC_FULL, SPEECH_MID);
		run_test("filtered speech", 40, 1'b1, DAC_RANDOM, SPEECH_RANDOM);
		run_test("saturation", 4 * SWING_RUN, 1'b1, DAC_RANDOM, SPEECH_SWING);
		run_test("strobe shape", 6, 1'b0, DAC_RANDOM, SPEECH_RANDOM);

		$display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0 && error_count == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/audio_mixer.sv */
////////////////////
// Output side of the sound path.
// Adds the averaged DAC level and the speech of the selected
// source, scales to 16 bits and registers one mono sample.
////////////////////

`default_nettype none

`include "sound_macros.svh"

module audio_mixer import sound_pkg::*; (
	input  wire logic     clk_sys,
	input  wire logic     reset,
	input  wire logic     sinistar_board,
	input  snd_filtered_t filtered,
	input  wire logic     filt_valid,
	output audio_word_t   audio_out,
	output logic          audio_valid
);

	localparam int SUM_BITS = `SND_WORD_BITS + 1;

	speech_word_t        speech_sel;
	logic [SUM_BITS-1:0] mix_sum;

	// Only the Sinistar board has the speech filter
	assign speech_sel = sinistar_board ? filtered.speech_filt : filtered.speech_raw;

	// DAC level sits in the upper byte
	assign mix_sum = SUM_BITS'({filtered.level, 8'h00}) + SUM_BITS'(speech_sel);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			audio_out   <= '0;
			audio_valid <= 1'b0;
		end else begin
			audio_valid <= filt_valid;
			if (filt_valid) begin
				audio_out <= audio_word_t'(mix_sum >> `SND_MIX_SHIFT);
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/dac_boxcar.sv */
////////////////////
// Input side of the sound path.
// Averages the 8-bit DAC over a 256-cycle window, latches the
// speech word in the last cycle and strobes the sample tick.
////////////////////

`default_nettype none

`include "sound_macros.svh"

module dac_boxcar import sound_pkg::*; (
	input  wire logic  clk_sys,
	input  wire logic  reset,
	input  dac_level_t dac_level,
	input  speech_word_t speech_word,
	output snd_sample_t sample,
	output logic       sample_valid
);

	localparam int SUM_BITS = `SND_DAC_BITS + `SND_WINDOW_BITS;

	logic [`SND_WINDOW_BITS-1:0] window_cnt;
	logic [SUM_BITS-1:0]         accum;
	logic [SUM_BITS-1:0]         accum_next;
	logic                        window_end;

	// Sum including the sample of this cycle
	assign accum_next = accum + SUM_BITS'(dac_level);
	assign window_end = (window_cnt == `SND_WINDOW_LEN - 1);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			window_cnt   <= '0;
			accum        <= '0;
			sample_valid <= 1'b0;
		end else begin
			window_cnt   <= window_cnt + 1'b1;
			sample_valid <= window_end;
			if (window_end) begin
				accum <= '0;
			end else begin
				accum <= accum_next;
			end
		end
	end

	// Upper byte of the window sum is the average
	always_ff @(posedge clk_sys) begin
		if (window_end) begin
			sample.level  <= accum_next[SUM_BITS-1 -: `SND_DAC_BITS];
			sample.speech <= speech_word;
		end
	end

endmodule

`default_nettype wire

/* verilog/sound_macros.svh */
////////////////////
// Constants for the sound output path.
// Window length, IIR coefficients with their scale, gain
// and the data widths. Include once per file that needs them.
////////////////////

`ifndef SOUND_MACROS_SVH
`define SOUND_MACROS_SVH

// Boxcar window of the DAC averager
`define SND_WINDOW_LEN   256
`define SND_WINDOW_BITS  8

// Data widths
`define SND_DAC_BITS     8
`define SND_WORD_BITS    16
`define SND_COEFF_BITS   22

// Offset binary midpoint of the speech word
`define SND_PCM_OFFSET   16'h8000

// Coefficient fraction bits
`define SND_COEFF_SCALE  15

// Stage 1 low pass, f0 near 3.5 kHz
`define SND_LPF1_A2      (-44251)
`define SND_LPF1_A3      16754
`define SND_LPF1_B1      1318
`define SND_LPF1_B2      2636
`define SND_LPF1_B3      1318

// Stage 2 low pass, f0 near 3.3 kHz
`define SND_LPF2_A2      (-45163)
`define SND_LPF2_A3      17301
`define SND_LPF2_B1      1226
`define SND_LPF2_B2      2453
`define SND_LPF2_B3      1226

// Speech boost after the filter, and the final mix scale
`define SND_GAIN_SHIFT   2
`define SND_MIX_SHIFT    3

`endif

/* verilog/sound_pkg.sv */
////////////////////
// Shared types of the sound path.
// Vector types for levels, words and coefficients, and the
// structs that carry one sample tick through the pipeline.
////////////////////

`default_nettype none

`include "sound_macros.svh"

package sound_pkg;

	typedef logic        [`SND_DAC_BITS-1:0]   dac_level_t;
	typedef logic        [`SND_WORD_BITS-1:0]  speech_word_t;
	typedef logic signed [`SND_WORD_BITS-1:0]  pcm_t;
	typedef logic signed [`SND_COEFF_BITS-1:0] coeff_t;
	typedef logic        [`SND_WORD_BITS-1:0]  audio_word_t;

	// One window end, 24 bits
	typedef struct packed {
		dac_level_t   level;
		speech_word_t speech;
	} snd_sample_t;

	// Sample after the filter, 40 bits
	typedef struct packed {
		dac_level_t   level;
		speech_word_t speech_raw;
		speech_word_t speech_filt;
	} snd_filtered_t;

endpackage

`default_nettype wire

/* verilog/speech_biquad.sv */
////////////////////
// One second-order IIR section, direct form I.
// Coefficients are fixed point with SND_COEFF_SCALE fraction
// bits. Runs once per in_valid and saturates to 16 bits.
////////////////////

`default_nettype none

`include "sound_macros.svh"

module speech_biquad import sound_pkg::*; #(
	parameter coeff_t b1 = coeff_t'(`SND_LPF1_B1),
	parameter coeff_t b2 = coeff_t'(`SND_LPF1_B2),
	parameter coeff_t b3 = coeff_t'(`SND_LPF1_B3),
	parameter coeff_t a2 = coeff_t'(`SND_LPF1_A2),
	parameter coeff_t a3 = coeff_t'(`SND_LPF1_A3)
) (
	input  wire logic clk_sys,
	input  wire logic reset,
	input  pcm_t      in_pcm,
	input  wire logic in_valid,
	output pcm_t      out_pcm,
	output logic      out_valid
);

	// Five products of 22x16 bits need three guard bits
	localparam int ACC_BITS = `SND_COEFF_BITS + `SND_WORD_BITS + 3;

	pcm_t x1;
	pcm_t x2;
	pcm_t y1;
	pcm_t y2;
	pcm_t y_sat;

	logic signed [ACC_BITS-1:0] acc;
	logic signed [ACC_BITS-1:0] acc_scaled;

	////////////////////
	// Difference equation
	////////////////////

	always_comb begin
		acc = b1 * in_pcm + b2 * x1 + b3 * x2 - a2 * y1 - a3 * y2;
		acc_scaled = acc >>> `SND_COEFF_SCALE;
		if (acc_scaled > 32767) begin
			y_sat = 16'sh7FFF;
		end else if (acc_scaled < -32768) begin
			y_sat = 16'sh8000;
		end else begin
			y_sat = acc_scaled[`SND_WORD_BITS-1:0];
		end
	end

	////////////////////
	// History
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			x1        <= '0;
			x2        <= '0;
			y1        <= '0;
			y2        <= '0;
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
			if (in_valid) begin
				x1 <= in_pcm;
				x2 <= x1;
				y1 <= y_sat;
				y2 <= y1;
			end
		end
	end

	// Newest output doubles as the y[n-1] term
	assign out_pcm = y1;

endmodule

`default_nettype wire

/* verilog/speech_lpf.sv */
////////////////////
// Processing part of the sound path.
// Two low-pass biquads in series on the speech word, then a
// 4x boost with clipping. Level and raw speech ride alongside.
////////////////////

`default_nettype none

`include "sound_macros.svh"

module speech_lpf import sound_pkg::*; (
	input  wire logic    clk_sys,
	input  wire logic    reset,
	input  snd_sample_t  sample,
	input  wire logic    sample_valid,
	output snd_filtered_t filtered,
	output logic         filt_valid
);

	localparam int BOOST_BITS = `SND_WORD_BITS + `SND_GAIN_SHIFT;

	pcm_t        speech_pcm;
	pcm_t        s1_pcm;
	pcm_t        s2_pcm;
	pcm_t        s_final;
	logic        s1_valid;
	snd_sample_t s1_side;
	snd_sample_t s2_side;

	logic signed [BOOST_BITS-1:0] boosted;

	// Offset binary to two's complement
	assign speech_pcm = pcm_t'(sample.speech ^ `SND_PCM_OFFSET);

	speech_biquad #(
		.b1(coeff_t'(`SND_LPF1_B1)),
		.b2(coeff_t'(`SND_LPF1_B2)),
		.b3(coeff_t'(`SND_LPF1_B3)),
		.a2(coeff_t'(`SND_LPF1_A2)),
		.a3(coeff_t'(`SND_LPF1_A3))
	) lpf_stage1 (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.in_pcm   (speech_pcm),
		.in_valid (sample_valid),
		.out_pcm  (s1_pcm),
		.out_valid(s1_valid)
	);

	speech_biquad #(
		.b1(coeff_t'(`SND_LPF2_B1)),
		.b2(coeff_t'(`SND_LPF2_B2)),
		.b3(coeff_t'(`SND_LPF2_B3)),
		.a2(coeff_t'(`SND_LPF2_A2)),
		.a3(coeff_t'(`SND_LPF2_A3))
	) lpf_stage2 (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.in_pcm   (s1_pcm),
		.in_valid (s1_valid),
		.out_pcm  (s2_pcm),
		.out_valid(filt_valid)
	);

	// Side fields follow the two filter stages
	always_ff @(posedge clk_sys) begin
		if (sample_valid) begin
			s1_side <= sample;
		end
		if (s1_valid) begin
			s2_side <= s1_side;
		end
	end

	// Gain and clip
	always_comb begin
		boosted = BOOST_BITS'(s2_pcm) <<< `SND_GAIN_SHIFT;
		if (boosted > 32767) begin
			s_final = 16'sh7FFF;
		end else if (boosted < -32768) begin
			s_final = 16'sh8000;
		end else begin
			s_final = boosted[`SND_WORD_BITS-1:0];
		end
	end

	assign filtered = '{
		level:       s2_side.level,
		speech_raw:  s2_side.speech,
		speech_filt: speech_word_t'(s_final) ^ `SND_PCM_OFFSET
	};

endmodule

`default_nettype wire

/* verilog/williams_sound.sv */
////////////////////
// Top of the sound output path.
// DAC averager, speech filter and mixer in series. One mono
// sample leaves every 256 cycles with a one-cycle strobe.
////////////////////

`default_nettype none

module williams_sound import sound_pkg::*; (
	input  wire logic   clk_sys,
	input  wire logic   reset,
	input  dac_level_t  dac_level,
	input  speech_word_t speech_word,
	input  wire logic   sinistar_board,
	output audio_word_t audio_out,
	output logic        audio_valid
);

	snd_sample_t   sample;
	logic          sample_valid;
	snd_filtered_t filtered;
	logic          filt_valid;

	dac_boxcar i_dac_boxcar (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dac_level   (dac_level),
		.speech_word (speech_word),
		.sample      (sample),
		.sample_valid(sample_valid)
	);

	speech_lpf i_speech_lpf (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.sample      (sample),
		.sample_valid(sample_valid),
		.filtered    (filtered),
		.filt_valid  (filt_valid)
	);

	audio_mixer i_audio_mixer (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.sinistar_board(sinistar_board),
		.filtered      (filtered),
		.filt_valid    (filt_valid),
		.audio_out     (audio_out),
		.audio_valid   (audio_valid)
	);

endmodule

`default_nettype wire
